// ==== alu_macros.svh ====
// data and address widths, register map indices and offsets, command queue sizing
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define APB_DATA_W      32
`define APB_ADDR_W      32
`define REG_OFFSET      (`APB_ADDR_W / 8)   // bytes between registers

// write bank
`define WR_REG_NUM      3
`define REG_OP_A_IDX    0
`define REG_OP_B_IDX    1
`define REG_CMD_IDX     2
`define OP_W            3                   // opcode field in CMD

// read bank
`define RD_REG_NUM      3
`define REG_RESULT_IDX  0
`define REG_DONE_IDX    1
`define REG_STATUS_IDX  2
`define STATUS_OVF_BIT  8

`define CMD_FIFO_DEPTH  4
`define CMD_FIFO_PTR_W  2
`define CMD_FIFO_LVL_W  3                   // holds 0..depth

`endif

// ==== alu_pkg.sv ====
// alu opcode enum, command queue and engine state enums
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

    // codes 5..7 are undefined and compute to zero
    typedef enum logic [`OP_W-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } alu_op_e;

    // request side of the four-phase handshake
    typedef enum logic [1:0] {
        FIFO_IDLE,
        FIFO_REQ,
        FIFO_WAIT_ACK_LOW
    } fifo_rd_state_e;

    typedef enum logic [1:0] {
        ALU_IDLE,
        ALU_ACK,
        ALU_MUL_RUN,
        ALU_POST
    } alu_state_e;

endpackage

`default_nettype wire

// ==== apb_reg_file.sv ====
// APB slave with write register bank, read register bank and write valid pulses
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module apb_reg_file (
    input  logic                                    clk_i,
    input  logic                                    rstn_i,

    input  logic [`APB_ADDR_W-1:0]                  paddr_i,
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [`APB_DATA_W-1:0]                  pwdata_i,
    output logic                                    pready_o,
    output logic [`APB_DATA_W-1:0]                  prdata_o,

    input  logic [`RD_REG_NUM-1:0][`APB_DATA_W-1:0] rd_regs_i,
    input  logic [`RD_REG_NUM-1:0]                  rd_valid_i,

    output logic [`WR_REG_NUM-1:0][`APB_DATA_W-1:0] wr_regs_o,
    output logic [`WR_REG_NUM-1:0]                  wr_valid_o
);

    logic [`APB_DATA_W-1:0] wr_reg [`WR_REG_NUM];
    logic [`APB_DATA_W-1:0] rd_reg [`RD_REG_NUM];
    logic [`WR_REG_NUM-1:0] wr_valid;

    logic access;
    logic write;
    logic read;

    // only the first access cycle counts, the next one completes the transfer
    assign access = psel_i & penable_i & ~pready_o;
    assign write  = access & pwrite_i;
    assign read   = access & ~pwrite_i;

    // write bank, first stage
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `WR_REG_NUM; i++) begin
                wr_reg[i]   <= '0;
                wr_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `WR_REG_NUM; i++) begin
                if (write && (paddr_i == `APB_ADDR_W'(i * `REG_OFFSET))) begin
                    wr_reg[i]   <= pwdata_i;
                    wr_valid[i] <= 1'b1;
                end else begin
                    wr_valid[i] <= 1'b0;
                end
            end
        end
    end

    // second stage toward the queue
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_valid_o <= '0;
        end else begin
            wr_valid_o <= wr_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `WR_REG_NUM; i++) begin
            wr_regs_o[i] <= wr_reg[i];
        end
    end

    // read bank, loaded by the subsystem
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RD_REG_NUM; i++) begin
                rd_reg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RD_REG_NUM; i++) begin
                if (rd_valid_i[i]) begin
                    rd_reg[i] <= rd_regs_i[i];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read) begin
            prdata_o <= '0; // unmapped offsets read zero
            for (int i = 0; i < `RD_REG_NUM; i++) begin
                if (paddr_i == `APB_ADDR_W'(i * `REG_OFFSET)) begin
                    prdata_o <= rd_reg[i];
                end
            end
        end
    end

    // one-cycle ready, same edge as prdata
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pready_o <= 1'b0;
        end else begin
            pready_o <= access;
        end
    end

endmodule

`default_nettype wire

// ==== cmd_fifo.sv ====
// command queue with four-phase req/ack read side, level and sticky overflow status
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module cmd_fifo (
    input  logic                                    clk_i,
    input  logic                                    rstn_i,

    input  logic [`WR_REG_NUM-1:0][`APB_DATA_W-1:0] wr_regs_i,
    input  logic [`WR_REG_NUM-1:0]                  wr_valid_i,

    output logic                                    req_o,
    input  logic                                    ack_i,
    output logic [`APB_DATA_W-1:0]                  cmd_a_o,
    output logic [`APB_DATA_W-1:0]                  cmd_b_o,
    output alu_pkg::alu_op_e                        cmd_op_o,

    output logic [`APB_DATA_W-1:0]                  status_o,
    output logic                                    status_valid_o
);

    import alu_pkg::*;

    logic [`APB_DATA_W-1:0]     a_mem  [`CMD_FIFO_DEPTH];
    logic [`APB_DATA_W-1:0]     b_mem  [`CMD_FIFO_DEPTH];
    alu_op_e                    op_mem [`CMD_FIFO_DEPTH];

    logic [`CMD_FIFO_PTR_W-1:0] wr_ptr;
    logic [`CMD_FIFO_PTR_W-1:0] rd_ptr;
    logic [`CMD_FIFO_LVL_W-1:0] level;
    logic [`CMD_FIFO_LVL_W-1:0] level_nxt;
    logic                       ovf;
    logic                       ovf_nxt;
    logic                       push;
    logic                       push_ok;
    logic                       pop;
    fifo_rd_state_e             state;

    assign push    = wr_valid_i[`REG_CMD_IDX];  // a CMD write queues one operation
    assign push_ok = push & (level != `CMD_FIFO_LVL_W'(`CMD_FIFO_DEPTH));
    assign pop     = (state == FIFO_REQ) & ack_i;

    always_comb begin
        level_nxt = level;
        if (push_ok && !pop) begin
            level_nxt = level + 1'b1;
        end else if (pop && !push_ok) begin
            level_nxt = level - 1'b1;
        end
        ovf_nxt = ovf | (push & ~push_ok); // dropped push
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            a_mem[wr_ptr]  <= wr_regs_i[`REG_OP_A_IDX];
            b_mem[wr_ptr]  <= wr_regs_i[`REG_OP_B_IDX];
            op_mem[wr_ptr] <= alu_op_e'(wr_regs_i[`REG_CMD_IDX][`OP_W-1:0]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            level          <= '0;
            ovf            <= 1'b0;
            status_valid_o <= 1'b0;
            req_o          <= 1'b0;
            state          <= FIFO_IDLE;
        end else begin
            level          <= level_nxt;
            ovf            <= ovf_nxt;
            status_valid_o <= (level_nxt != level) | (ovf_nxt != ovf);
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case (state)
                FIFO_IDLE: begin
                    if ((level != '0) && !ack_i) begin
                        req_o <= 1'b1;
                        state <= FIFO_REQ;
                    end
                end
                FIFO_REQ: begin
                    if (ack_i) begin
                        req_o <= 1'b0;  // entry popped on this edge
                        state <= FIFO_WAIT_ACK_LOW;
                    end
                end
                FIFO_WAIT_ACK_LOW: begin
                    if (!ack_i) begin
                        state <= FIFO_IDLE;
                    end
                end
                default: state <= FIFO_IDLE;
            endcase
        end
    end

    // head entry, stable while req is high
    assign cmd_a_o  = a_mem[rd_ptr];
    assign cmd_b_o  = b_mem[rd_ptr];
    assign cmd_op_o = op_mem[rd_ptr];

    assign status_o = {{(`APB_DATA_W - `STATUS_OVF_BIT - 1){1'b0}}, ovf,
                       {(`STATUS_OVF_BIT - `CMD_FIFO_LVL_W){1'b0}}, level};

endmodule

`default_nettype wire

// ==== alu_engine.sv ====
// command consumer with single-cycle ops, shift-and-add multiply and done counter
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_engine (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    input  logic                   req_i,
    output logic                   ack_o,
    input  logic [`APB_DATA_W-1:0] cmd_a_i,
    input  logic [`APB_DATA_W-1:0] cmd_b_i,
    input  alu_pkg::alu_op_e       cmd_op_i,

    output logic [`APB_DATA_W-1:0] result_o,
    output logic [`APB_DATA_W-1:0] done_count_o,
    output logic                   result_valid_o
);

    import alu_pkg::*;

    alu_state_e                       state;
    alu_op_e                          op;
    logic [`APB_DATA_W-1:0]           op_a;
    logic [`APB_DATA_W-1:0]           op_b;
    logic [`APB_DATA_W-1:0]           acc;
    logic [$clog2(`APB_DATA_W)-1:0]   step;
    logic                             take;

    function automatic logic [`APB_DATA_W-1:0] alu_simple(
        input alu_op_e                op_f,
        input logic [`APB_DATA_W-1:0] a,
        input logic [`APB_DATA_W-1:0] b
    );
        logic [`APB_DATA_W-1:0] res;
        case (op_f)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_XOR:  res = a ^ b;
            default: res = '0;  // undefined codes
        endcase
        return res;
    endfunction

    // accept only from idle, after the previous handshake has closed
    assign take = (state == ALU_IDLE) & req_i & ~ack_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state          <= ALU_IDLE;
            ack_o          <= 1'b0;
            result_valid_o <= 1'b0;
            done_count_o   <= '0;
        end else begin
            result_valid_o <= 1'b0;
            if (take) begin
                ack_o <= 1'b1;
            end else if (ack_o && !req_i) begin
                ack_o <= 1'b0;  // req gone, close the handshake
            end

            case (state)
                ALU_IDLE: begin
                    if (take) begin
                        state <= ALU_ACK;
                    end
                end
                ALU_ACK: begin
                    if (op == OP_MUL) begin
                        state <= ALU_MUL_RUN;
                    end else begin
                        result_valid_o <= 1'b1;
                        done_count_o   <= done_count_o + 1'b1;
                        state          <= ALU_IDLE;
                    end
                end
                ALU_MUL_RUN: begin
                    if (step == '1) begin
                        state <= ALU_POST;
                    end
                end
                ALU_POST: begin
                    result_valid_o <= 1'b1;
                    done_count_o   <= done_count_o + 1'b1;
                    state          <= ALU_IDLE;
                end
                default: state <= ALU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state)
            ALU_IDLE: begin
                if (take) begin
                    op_a <= cmd_a_i;
                    op_b <= cmd_b_i;
                    op   <= cmd_op_i;
                end
            end
            ALU_ACK: begin
                acc  <= '0;
                step <= '0;
                if (op != OP_MUL) begin
                    result_o <= alu_simple(op, op_a, op_b);
                end
            end
            ALU_MUL_RUN: begin
                if (op_b[0]) begin
                    acc <= acc + op_a;
                end
                op_a <= op_a << 1;   // low 32 bits of the product only
                op_b <= op_b >> 1;
                step <= step + 1'b1;
            end
            ALU_POST: result_o <= acc;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_subsys_top.sv ====
// top level wiring of APB register file, command queue and arithmetic engine
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_subsys_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`APB_DATA_W-1:0] pwdata_i,
    output logic                   pready_o,
    output logic [`APB_DATA_W-1:0] prdata_o
);

    import alu_pkg::*;

    logic [`WR_REG_NUM-1:0][`APB_DATA_W-1:0] wr_regs;
    logic [`WR_REG_NUM-1:0]                  wr_valid;
    logic [`RD_REG_NUM-1:0][`APB_DATA_W-1:0] rd_regs;
    logic [`RD_REG_NUM-1:0]                  rd_valid;

    logic                   req;
    logic                   ack;
    logic [`APB_DATA_W-1:0] cmd_a;
    logic [`APB_DATA_W-1:0] cmd_b;
    alu_op_e                cmd_op;
    logic [`APB_DATA_W-1:0] result;
    logic [`APB_DATA_W-1:0] done_count;
    logic                   result_valid;
    logic [`APB_DATA_W-1:0] status;
    logic                   status_valid;

    // result and count post together
    assign rd_regs[`REG_RESULT_IDX]  = result;
    assign rd_regs[`REG_DONE_IDX]    = done_count;
    assign rd_regs[`REG_STATUS_IDX]  = status;
    assign rd_valid[`REG_RESULT_IDX] = result_valid;
    assign rd_valid[`REG_DONE_IDX]   = result_valid;
    assign rd_valid[`REG_STATUS_IDX] = status_valid;

    apb_reg_file reg_file0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .paddr_i    (paddr_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),
        .pready_o   (pready_o),
        .prdata_o   (prdata_o),
        .rd_regs_i  (rd_regs),
        .rd_valid_i (rd_valid),
        .wr_regs_o  (wr_regs),
        .wr_valid_o (wr_valid)
    );

    cmd_fifo fifo0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .wr_regs_i      (wr_regs),
        .wr_valid_i     (wr_valid),
        .req_o          (req),
        .ack_i          (ack),
        .cmd_a_o        (cmd_a),
        .cmd_b_o        (cmd_b),
        .cmd_op_o       (cmd_op),
        .status_o       (status),
        .status_valid_o (status_valid)
    );

    alu_engine engine0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req),
        .ack_o          (ack),
        .cmd_a_i        (cmd_a),
        .cmd_b_i        (cmd_b),
        .cmd_op_i       (cmd_op),
        .result_o       (result),
        .done_count_o   (done_count),
        .result_valid_o (result_valid)
    );

endmodule

`default_nettype wire

// ==== alu_asserts.sv ====
// concurrent APB and req/ack handshake assertions, bound into the subsystem top
`timescale 1ns/1ps
`default_nettype none

module alu_asserts (
    input logic clk_i,
    input logic rstn_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic req_i,
    input logic ack_i
);

    int unsigned fail_cnt;

    initial fail_cnt = 0;

    // access phase only after a setup cycle
    penable_after_setup: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $rose(penable_i) |-> psel_i && $past(psel_i)
    ) else begin
        fail_cnt++;
        $error("penable rose without a setup cycle before it");
    end

    pready_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        pready_i |=> !pready_i
    ) else begin
        fail_cnt++;
        $error("pready stayed high for more than one cycle");
    end

    req_held_until_ack: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        req_i && !ack_i |=> req_i
    ) else begin
        fail_cnt++;
        $error("req dropped before ack");
    end

    // four-phase: ack closes after req is gone
    ack_falls_after_req: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $fell(ack_i) |-> !$past(req_i)
    ) else begin
        fail_cnt++;
        $error("ack fell while req was still high");
    end

endmodule

bind alu_subsys_top alu_asserts asserts0 (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .req_i     (req),
    .ack_i     (ack)
);

`default_nettype wire

// ==== alu_checker.sv ====
// scoreboard with APB monitor, register and queue model, reference function and read compare
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_checker (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`APB_DATA_W-1:0] pwdata_i,
    input  logic                   pready_i,
    input  logic [`APB_DATA_W-1:0] prdata_i,
    output int unsigned            err_cnt_o,
    output int unsigned            chk_cnt_o
);

    import alu_pkg::*;

    logic [`APB_DATA_W-1:0] op_a;
    logic [`APB_DATA_W-1:0] op_b;
    logic [`APB_DATA_W-1:0] results [$];    // every accepted command, oldest first
    int unsigned            done_seen;      // last DONE_COUNT read
    logic                   ovf;

    function automatic logic [`APB_DATA_W-1:0] alu_ref(
        input logic [`OP_W-1:0]       code,
        input logic [`APB_DATA_W-1:0] a,
        input logic [`APB_DATA_W-1:0] b
    );
        case (code)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;  // low word of the product
            default: return '0;
        endcase
    endfunction

    // accepted but not seen done; the oldest one sits in the engine
    function automatic int unsigned pending();
        return results.size() - done_seen;
    endfunction

    task automatic model_write(input int idx, input logic [`APB_DATA_W-1:0] data);
        case (idx)
            `REG_OP_A_IDX: op_a = data;
            `REG_OP_B_IDX: op_b = data;
            `REG_CMD_IDX: begin
                if (pending() > `CMD_FIFO_DEPTH) begin
                    ovf = 1'b1;     // queue full, command dropped
                end else begin
                    results.push_back(alu_ref(data[`OP_W-1:0], op_a, op_b));
                end
            end
            default: ;
        endcase
    endtask

    task automatic compare_read(input int idx, input logic [`APB_DATA_W-1:0] data);
        logic [`APB_DATA_W-1:0] expected;
        int unsigned            level;
        string                  name;
        expected = '0;
        level    = (pending() > 0) ? pending() - 1 : 0;
        chk_cnt_o++;
        if (idx == `REG_DONE_IDX) begin
            // count only moves up and never past the accepted commands
            if ((data < done_seen) || (data > results.size())) begin
                err_cnt_o++;
                $display("Mismatch at %0d ns: DONE_COUNT expected %0d to %0d actual %0d",
                         $time, done_seen, results.size(), data);
            end else begin
                done_seen = data;
            end
        end else begin
            case (idx)
                `REG_RESULT_IDX: begin
                    name = "RESULT";
                    if (done_seen > 0) begin
                        expected = results[done_seen - 1];
                    end
                end
                `REG_STATUS_IDX: begin
                    name = "STATUS";
                    expected[`STATUS_OVF_BIT]       = ovf;
                    expected[`CMD_FIFO_LVL_W-1:0]   = `CMD_FIFO_LVL_W'(level);
                end
                default: name = "unmapped";
            endcase
            if (data !== expected) begin
                err_cnt_o++;
                $display("Mismatch at %0d ns: %s expected 0x%08h actual 0x%08h",
                         $time, name, expected, data);
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            op_a      = '0;
            op_b      = '0;
            ovf       = 1'b0;
            done_seen = 0;
            err_cnt_o = 0;
            chk_cnt_o = 0;
            results.delete();
        end else begin
            if (pready_i && !(psel_i && penable_i)) begin
                err_cnt_o++;
                $display("pready was high outside an APB transfer at %0d ns", $time);
            end
            if (psel_i && penable_i && pready_i) begin  // transfer completes here
                if (pwrite_i) begin
                    model_write(int'(paddr_i / `REG_OFFSET), pwdata_i);
                end else begin
                    compare_read(int'(paddr_i / `REG_OFFSET), prdata_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_alu_subsys.sv ====
// testbench top with clock, reset, APB master, LFSR stimulus, watchdog and result line
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module tb_alu_subsys;

    import alu_pkg::*;

    localparam int NUM_CMDS  = 19;
    localparam int MAX_POLLS = 40;
    localparam logic [`OP_W-1:0] SINGLE_OPS [6] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL,
                                                   3'd6};

    logic                   clk_i;
    logic                   rstn_i;
    logic [`APB_ADDR_W-1:0] paddr_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [`APB_DATA_W-1:0] pwdata_i;
    logic                   pready_o;
    logic [`APB_DATA_W-1:0] prdata_o;

    int unsigned            checker_errs;
    int unsigned            checker_checks;
    int unsigned            tb_errs;
    int unsigned            tb_checks;
    int unsigned            total_errs;
    int unsigned            exp_done;
    logic [31:0]            lfsr;
    logic [`APB_DATA_W-1:0] rdata;

    alu_subsys_top dut0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .pready_o  (pready_o),
        .prdata_o  (prdata_o)
    );

    alu_checker checker0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .pready_i  (pready_o),
        .prdata_i  (prdata_o),
        .err_cnt_o (checker_errs),
        .chk_cnt_o (checker_checks)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic transfer(input logic wr, input int idx, input logic [`APB_DATA_W-1:0] wdata,
                            output logic [`APB_DATA_W-1:0] data);
        @(posedge clk_i);
        paddr_i   <= `APB_ADDR_W'(idx * `REG_OFFSET);
        pwrite_i  <= wr;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        @(posedge clk_i);
        penable_i <= 1'b1;
        do begin
            @(negedge clk_i);
        end while (!pready_o);
        data = prdata_o;
        @(posedge clk_i);   // transfer completes on this edge
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic wait_done(input int unsigned target);
        int polls;
        polls = 0;
        do begin
            transfer(1'b0, `REG_DONE_IDX, '0, rdata);
            polls++;
        end while ((rdata != target) && (polls < MAX_POLLS));
        tb_checks++;
        if (rdata != target) begin
            tb_errs++;
            $display("Mismatch at %0d ns: DONE_COUNT expected %0d actual %0d",
                     $time, target, rdata);
        end
    endtask

    task automatic compare_field(input string name, input int unsigned got,
                                 input int unsigned want);
        tb_checks++;
        if (got != want) begin
            tb_errs++;
            $display("Mismatch at %0d ns: %s expected %0d actual %0d", $time, name, want, got);
        end
    endtask

    task automatic run_op(input logic [`OP_W-1:0] code);
        transfer(1'b1, `REG_OP_A_IDX, random_bits(32), rdata);
        transfer(1'b1, `REG_OP_B_IDX, random_bits(32), rdata);
        transfer(1'b1, `REG_CMD_IDX, `APB_DATA_W'(code), rdata);
        exp_done++;
        wait_done(exp_done);
        transfer(1'b0, `REG_RESULT_IDX, '0, rdata);
    endtask

    initial begin
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        paddr_i   = '0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        pwdata_i  = '0;
        lfsr      = 32'h75f4;
        tb_errs   = 0;
        tb_checks = 0;
        exp_done  = 0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        // read bank after reset
        transfer(1'b0, `REG_RESULT_IDX, '0, rdata);
        transfer(1'b0, `REG_DONE_IDX, '0, rdata);
        transfer(1'b0, `REG_STATUS_IDX, '0, rdata);

        for (int i = 0; i < 6; i++) begin
            run_op(SINGLE_OPS[i]);
        end

        // three adds queue up behind a running multiply
        transfer(1'b1, `REG_OP_A_IDX, random_bits(32), rdata);
        transfer(1'b1, `REG_OP_B_IDX, random_bits(32), rdata);
        transfer(1'b1, `REG_CMD_IDX, `APB_DATA_W'(OP_MUL), rdata);
        for (int i = 0; i < 3; i++) begin
            if (i == 0) begin
                transfer(1'b1, `REG_OP_A_IDX, random_bits(32), rdata);
            end
            transfer(1'b1, `REG_OP_B_IDX, random_bits(32), rdata);
            transfer(1'b1, `REG_CMD_IDX, `APB_DATA_W'(OP_ADD), rdata);
        end
        transfer(1'b0, `REG_STATUS_IDX, '0, rdata);
        compare_field("STATUS level", rdata[`CMD_FIFO_LVL_W-1:0], 3);
        exp_done += 4;
        wait_done(exp_done);
        transfer(1'b0, `REG_RESULT_IDX, '0, rdata);

        // depth + 1 commands while the multiply runs, the last one is dropped
        transfer(1'b1, `REG_OP_A_IDX, random_bits(32), rdata);
        transfer(1'b1, `REG_OP_B_IDX, random_bits(32), rdata);
        transfer(1'b1, `REG_CMD_IDX, `APB_DATA_W'(OP_MUL), rdata);
        for (int i = 0; i < `CMD_FIFO_DEPTH + 1; i++) begin
            transfer(1'b1, `REG_CMD_IDX, random_bits(2), rdata);
        end
        transfer(1'b0, `REG_STATUS_IDX, '0, rdata);
        compare_field("STATUS overflow", rdata[`STATUS_OVF_BIT], 1);
        exp_done += `CMD_FIFO_DEPTH + 1;
        wait_done(exp_done);
        transfer(1'b0, `REG_RESULT_IDX, '0, rdata);

        for (int i = 0; i < 3; i++) begin
            run_op(random_bits(`OP_W));
        end
        transfer(1'b0, `REG_STATUS_IDX, '0, rdata);
        compare_field("STATUS overflow", rdata[`STATUS_OVF_BIT], 1);

        repeat (2) @(posedge clk_i);
        total_errs = tb_errs + checker_errs + dut0.asserts0.fail_cnt;
        $display("errors: %0d, checks: %0d", total_errs, tb_checks + checker_checks);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (NUM_CMDS * 40 + 200) @(posedge clk_i);
        $display("timeout, run did not finish within %0d cycles", NUM_CMDS * 40 + 200);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
alu_pkg.sv
apb_reg_file.sv
cmd_fifo.sv
alu_engine.sv
alu_subsys_top.sv
alu_asserts.sv
alu_checker.sv
tb_alu_subsys.sv
